// File: hw/kv_defines_pkg.sv
// key vault shared definitions
`default_nettype none

package kv_defines_pkg;

    // one beat of a transfer carries one dword
    parameter int KV_DWORD_W = 32;

    // destination-valid field, one bit per consumer
    // that may later read the entry
    parameter int KV_DEST_W = 6;

    // response code kept by the write client
    // reflects the store response to the latest beat
    typedef enum logic [7:0] {
        KV_SUCCESS    = 8'h00,
        KV_WRITE_FAIL = 8'h01
    } kv_error_code_e;

endpackage

`default_nettype wire

// File: hw/kv_fsm.sv
// write transfer sequencer
`timescale 1ns/10ps
`default_nettype none

module kv_fsm (
    input  logic clk,
    input  logic rst_b,
    input  logic zeroize,
    input  logic start,
    input  logic at_last,
    output logic ready,
    output logic wr_beat,
    output logic clr,
    output logic step,
    output logic wr_last,
    output logic done
);

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        WRITE = 2'd1,
        DONE  = 2'd2
    } kv_fsm_state_e;

    kv_fsm_state_e state;
    kv_fsm_state_e state_nxt;

    // zeroize drops any transfer in flight
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            state <= IDLE;
        end else if (zeroize) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            // wait for a level start from the client
            IDLE: begin
                if (start) begin
                    state_nxt = WRITE;
                end
            end
            // one dword per cycle until the counter hits the end
            WRITE: begin
                if (at_last) begin
                    state_nxt = DONE;
                end
            end
            // ready again here, so a new start may follow directly
            DONE: begin
                state_nxt = start ? WRITE : IDLE;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_comb begin
        ready   = (state == IDLE) || (state == DONE);
        done    = (state == DONE);
        wr_beat = (state == WRITE);
        // offset advances with every beat
        step    = wr_beat;
        wr_last = wr_beat & at_last;
        // counter back to zero as the transfer begins
        clr     = ready & start;
    end

    // a beat only goes out after a start was taken while ready
    a_beat_after_start: assert property (
        @(posedge clk) disable iff (!rst_b)
        (ready && !start) |=> !wr_beat
    );

endmodule

`default_nettype wire

// File: hw/kv_offset_counter.sv
// dword offset counter
`timescale 1ns/10ps
`default_nettype none

module kv_offset_counter #(
    parameter int DATA_WIDTH = 512
) (
    input  logic                               clk,
    input  logic                               rst_b,
    input  logic                               zeroize,
    input  logic                               clr,
    input  logic                               step,
    input  logic [$clog2(DATA_WIDTH/32):0]     num_dwords,
    output logic [$clog2(DATA_WIDTH/32)-1:0]   offset,
    output logic                               at_last
);

    localparam int DATA_OFFSET_W = $clog2(DATA_WIDTH/32);

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            offset <= '0;
        end else if (zeroize || clr) begin
            offset <= '0;
        end else if (step) begin
            offset <= offset + 1'b1;
        end
    end

    // final beat of the requested length
    always_comb begin
        at_last = ({1'b0, offset} == (num_dwords - 1'b1));
    end

    // the fsm must stop stepping once the last dword went out
    a_step_in_range: assert property (
        @(posedge clk) disable iff (!rst_b)
        step |-> ({1'b0, offset} < num_dwords)
    );

    // keep the offset width tied to the dword count
    initial begin
        if (DATA_WIDTH % 32 != 0) begin
            $error("DATA_WIDTH %0d is not a multiple of 32", DATA_WIDTH);
        end
        if (DATA_OFFSET_W < 1) begin
            $error("DATA_WIDTH %0d gives fewer than two dwords", DATA_WIDTH);
        end
    end

endmodule

`default_nettype wire

// File: hw/kv_write_client.sv
// key vault write client
`timescale 1ns/10ps
`default_nettype none

module kv_write_client #(
    parameter int DATA_WIDTH  = 512,
    parameter int NUM_ENTRIES = 8
) (
    input  logic                                   clk,
    input  logic                                   rst_b,
    input  logic                                   zeroize,
    input  logic [$clog2(DATA_WIDTH/32):0]         num_dwords,
    // write control from the client block
    input  logic                                   write_en,
    input  logic [$clog2(NUM_ENTRIES)-1:0]         write_entry,
    input  logic [kv_defines_pkg::KV_DEST_W-1:0]   write_dest_vld,
    input  logic                                   dest_data_avail,
    input  logic [DATA_WIDTH-1:0]                  dest_data,
    // store response, same cycle as the beat
    input  logic                                   wr_error,
    output logic                                   dest_keyvault,
    // store beat
    output logic                                   wr_en,
    output logic [$clog2(NUM_ENTRIES)-1:0]         wr_entry,
    output logic [$clog2(DATA_WIDTH/32)-1:0]       wr_offset,
    output logic [kv_defines_pkg::KV_DWORD_W-1:0]  wr_data,
    output logic [kv_defines_pkg::KV_DEST_W-1:0]   wr_dest_valid,
    output kv_defines_pkg::kv_error_code_e         error_code,
    output logic                                   kv_ready,
    output logic                                   dest_done
);

    localparam int DATA_OFFSET_W   = $clog2(DATA_WIDTH/32);
    localparam int DATA_NUM_DWORDS = DATA_WIDTH / 32;

    logic                     start;
    logic                     wr_beat;
    logic                     wr_last;
    logic                     cnt_clr;
    logic                     cnt_step;
    logic                     at_last;
    logic [DATA_OFFSET_W-1:0] offset;
    logic [DATA_OFFSET_W-1:0] sel;

    // client result only counts when the vault write is enabled
    always_comb begin
        start = dest_data_avail & write_en;
    end

    kv_fsm u_fsm (
        .clk     (clk),
        .rst_b   (rst_b),
        .zeroize (zeroize),
        .start   (start),
        .at_last (at_last),
        .ready   (kv_ready),
        .wr_beat (wr_beat),
        .clr     (cnt_clr),
        .step    (cnt_step),
        .wr_last (wr_last),
        .done    (dest_done)
    );

    kv_offset_counter #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_offset_counter (
        .clk        (clk),
        .rst_b      (rst_b),
        .zeroize    (zeroize),
        .clr        (cnt_clr),
        .step       (cnt_step),
        .num_dwords (num_dwords),
        .offset     (offset),
        .at_last    (at_last)
    );

    // most significant dword goes out first
    always_comb begin
        sel = DATA_OFFSET_W'(DATA_NUM_DWORDS - 1) - offset;
    end

    always_comb begin
        dest_keyvault = write_en;
        wr_en         = wr_beat;
        wr_entry      = write_entry;
        wr_offset     = offset;
        wr_data       = dest_data[sel*kv_defines_pkg::KV_DWORD_W +: kv_defines_pkg::KV_DWORD_W];
        // dest field stays zero until the final beat
        wr_dest_valid = wr_last ? write_dest_vld : '0;
    end

    // error code follows the response to the latest beat
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            error_code <= kv_defines_pkg::KV_SUCCESS;
        end else if (zeroize) begin
            error_code <= kv_defines_pkg::KV_SUCCESS;
        end else if (wr_en) begin
            error_code <= wr_error ? kv_defines_pkg::KV_WRITE_FAIL
                                   : kv_defines_pkg::KV_SUCCESS;
        end
    end

endmodule

`default_nettype wire

// File: hw/kv_store.sv
// key vault entry storage
`timescale 1ns/10ps
`default_nettype none

module kv_store #(
    parameter int DATA_WIDTH  = 512,
    parameter int NUM_ENTRIES = 8
) (
    input  logic                                   clk,
    input  logic                                   rst_b,
    input  logic                                   zeroize,
    // write beat from the client
    input  logic                                   wr_en,
    input  logic [$clog2(NUM_ENTRIES)-1:0]         wr_entry,
    input  logic [$clog2(DATA_WIDTH/32)-1:0]       wr_offset,
    input  logic [kv_defines_pkg::KV_DWORD_W-1:0]  wr_data,
    input  logic [kv_defines_pkg::KV_DEST_W-1:0]   wr_dest_valid,
    // one lock bit per entry, owned outside
    input  logic [NUM_ENTRIES-1:0]                 lock,
    input  logic [$clog2(NUM_ENTRIES)-1:0]         rd_entry,
    input  logic [$clog2(DATA_WIDTH/32)-1:0]       rd_offset,
    output logic                                   wr_error,
    output logic [kv_defines_pkg::KV_DWORD_W-1:0]  rd_data,
    output logic [kv_defines_pkg::KV_DEST_W-1:0]   rd_dest_valid
);

    localparam int DATA_NUM_DWORDS = DATA_WIDTH / 32;
    localparam int ENTRY_W         = $clog2(NUM_ENTRIES);

    // entry x dword storage and the dest field of each entry
    logic [NUM_ENTRIES-1:0][DATA_NUM_DWORDS-1:0][kv_defines_pkg::KV_DWORD_W-1:0] mem;
    logic [NUM_ENTRIES-1:0][kv_defines_pkg::KV_DEST_W-1:0] dest_vld;

    logic wr_ok;

    // locked entry refuses the beat
    always_comb begin
        wr_error = wr_en & lock[wr_entry];
        wr_ok    = wr_en & ~lock[wr_entry];
    end

    // zeroize wipes every entry, even with a write pending
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            mem <= '0;
        end else if (zeroize) begin
            mem <= '0;
        end else if (wr_ok) begin
            mem[wr_entry][wr_offset] <= wr_data;
        end
    end

    // every accepted beat overwrites the dest field
    // so it ends with the value of the final beat
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            dest_vld <= '0;
        end else if (zeroize) begin
            dest_vld <= '0;
        end else if (wr_ok) begin
            dest_vld[wr_entry] <= wr_dest_valid;
        end
    end

    // read port for consumers
    always_comb begin
        rd_data       = mem[rd_entry][rd_offset];
        rd_dest_valid = dest_vld[rd_entry];
    end

    // the client must address a real entry
    a_wr_entry_range: assert property (
        @(posedge clk) disable iff (!rst_b)
        wr_en |-> ({1'b0, wr_entry} < (ENTRY_W+1)'(NUM_ENTRIES))
    );

endmodule

`default_nettype wire

// File: hw/kv_vault_top.sv
// key vault write path top
`timescale 1ns/10ps
`default_nettype none

module kv_vault_top #(
    parameter int DATA_WIDTH  = 512,
    parameter int NUM_ENTRIES = 8
) (
    input  logic                                   clk,
    input  logic                                   rst_b,
    input  logic                                   zeroize,
    input  logic [$clog2(DATA_WIDTH/32):0]         num_dwords,
    input  logic                                   write_en,
    input  logic [$clog2(NUM_ENTRIES)-1:0]         write_entry,
    input  logic [kv_defines_pkg::KV_DEST_W-1:0]   write_dest_vld,
    input  logic                                   dest_data_avail,
    input  logic [DATA_WIDTH-1:0]                  dest_data,
    input  logic [NUM_ENTRIES-1:0]                 lock,
    input  logic [$clog2(NUM_ENTRIES)-1:0]         rd_entry,
    input  logic [$clog2(DATA_WIDTH/32)-1:0]       rd_offset,
    output logic [kv_defines_pkg::KV_DWORD_W-1:0]  rd_data,
    output logic [kv_defines_pkg::KV_DEST_W-1:0]   rd_dest_valid,
    output kv_defines_pkg::kv_error_code_e         error_code,
    output logic                                   kv_ready,
    output logic                                   dest_done,
    output logic                                   dest_keyvault
);

    localparam int DATA_OFFSET_W = $clog2(DATA_WIDTH/32);
    localparam int ENTRY_W       = $clog2(NUM_ENTRIES);

    // client to store beat
    logic                                  wr_en;
    logic [ENTRY_W-1:0]                    wr_entry;
    logic [DATA_OFFSET_W-1:0]              wr_offset;
    logic [kv_defines_pkg::KV_DWORD_W-1:0] wr_data;
    logic [kv_defines_pkg::KV_DEST_W-1:0]  wr_dest_valid;
    logic                                  wr_error;

    kv_write_client #(
        .DATA_WIDTH  (DATA_WIDTH),
        .NUM_ENTRIES (NUM_ENTRIES)
    ) u_write_client (
        .clk             (clk),
        .rst_b           (rst_b),
        .zeroize         (zeroize),
        .num_dwords      (num_dwords),
        .write_en        (write_en),
        .write_entry     (write_entry),
        .write_dest_vld  (write_dest_vld),
        .dest_data_avail (dest_data_avail),
        .dest_data       (dest_data),
        .wr_error        (wr_error),
        .dest_keyvault   (dest_keyvault),
        .wr_en           (wr_en),
        .wr_entry        (wr_entry),
        .wr_offset       (wr_offset),
        .wr_data         (wr_data),
        .wr_dest_valid   (wr_dest_valid),
        .error_code      (error_code),
        .kv_ready        (kv_ready),
        .dest_done       (dest_done)
    );

    kv_store #(
        .DATA_WIDTH  (DATA_WIDTH),
        .NUM_ENTRIES (NUM_ENTRIES)
    ) u_store (
        .clk           (clk),
        .rst_b         (rst_b),
        .zeroize       (zeroize),
        .wr_en         (wr_en),
        .wr_entry      (wr_entry),
        .wr_offset     (wr_offset),
        .wr_data       (wr_data),
        .wr_dest_valid (wr_dest_valid),
        .lock          (lock),
        .rd_entry      (rd_entry),
        .rd_offset     (rd_offset),
        .wr_error      (wr_error),
        .rd_data       (rd_data),
        .rd_dest_valid (rd_dest_valid)
    );

endmodule

`default_nettype wire

// File: verification/kv_vault_tb.sv
// key vault write path testbench
`timescale 1ns/10ps
`default_nettype none

module kv_vault_tb;

    localparam int DATA_WIDTH  = 512;
    localparam int NUM_ENTRIES = 8;
    localparam int NUM_DW      = DATA_WIDTH / 32;
    localparam int OFF_W       = $clog2(NUM_DW);
    localparam int ENTRY_W     = $clog2(NUM_ENTRIES);
    localparam int DEST_W      = kv_defines_pkg::KV_DEST_W;
    localparam int MAX_TESTS   = 32;

    logic                   clk;
    logic                   rst_b;
    logic                   zeroize;
    logic [OFF_W:0]         num_dwords;
    logic                   write_en;
    logic [ENTRY_W-1:0]     write_entry;
    logic [DEST_W-1:0]      write_dest_vld;
    logic                   dest_data_avail;
    logic [DATA_WIDTH-1:0]  dest_data;
    logic [NUM_ENTRIES-1:0] lock;
    logic [ENTRY_W-1:0]     rd_entry;
    logic [OFF_W-1:0]       rd_offset;
    logic [31:0]            rd_data;
    logic [DEST_W-1:0]      rd_dest_valid;
    kv_defines_pkg::kv_error_code_e error_code;
    logic                   kv_ready;
    logic                   dest_done;
    logic                   dest_keyvault;

    // trace columns, one slot per test
    string       t_name     [MAX_TESTS];
    int          t_zero_at  [MAX_TESTS];
    int          t_ndw      [MAX_TESTS];
    int          t_wen      [MAX_TESTS];
    int          t_entry    [MAX_TESTS];
    logic [31:0] t_dest     [MAX_TESTS];
    logic [31:0] t_lock     [MAX_TESTS];
    logic [31:0] t_seed     [MAX_TESTS];
    logic [31:0] t_err      [MAX_TESTS];
    logic [31:0] t_exp_dest [MAX_TESTS];

    // expected vault contents built from the transfer rules
    logic [31:0]       model_mem  [NUM_ENTRIES][NUM_DW];
    logic [DEST_W-1:0] model_dest [NUM_ENTRIES];

    string cur_name;
    int    test_errors;
    int    num_tests;
    int    pass_count;
    int    fail_count;
    int    cycle_count = 0;
    int    cycle_limit = 0;

    kv_vault_top #(
        .DATA_WIDTH  (DATA_WIDTH),
        .NUM_ENTRIES (NUM_ENTRIES)
    ) dut (
        .clk             (clk),
        .rst_b           (rst_b),
        .zeroize         (zeroize),
        .num_dwords      (num_dwords),
        .write_en        (write_en),
        .write_entry     (write_entry),
        .write_dest_vld  (write_dest_vld),
        .dest_data_avail (dest_data_avail),
        .dest_data       (dest_data),
        .lock            (lock),
        .rd_entry        (rd_entry),
        .rd_offset       (rd_offset),
        .rd_data         (rd_data),
        .rd_dest_valid   (rd_dest_valid),
        .error_code      (error_code),
        .kv_ready        (kv_ready),
        .dest_done       (dest_done),
        .dest_keyvault   (dest_keyvault)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // watchdog, limit set once the trace length is known
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, the tests did not complete", cycle_count);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic note_mismatch(input string what, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
        $display("FAIL %s %s expected %0h actual %0h", cur_name, what, exp_val, act_val);
        test_errors++;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            $display("test %s passed", cur_name);
            pass_count++;
        end else begin
            $display("test %s failed with %0d errors", cur_name, test_errors);
            fail_count++;
        end
    endtask

    task automatic load_trace();
        int          fd;
        int          rc;
        string       line;
        string       nm;
        int          zat;
        int          ndw;
        int          wen;
        int          ent;
        logic [31:0] dv;
        logic [31:0] lk;
        logic [31:0] sd;
        logic [31:0] er;
        logic [31:0] ed;
        num_tests = 0;
        fd = $fopen("verification/kv_vault_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            // column notes and blank lines
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            rc = $sscanf(line, "%s %d %d %d %d %h %h %h %h %h",
                         nm, zat, ndw, wen, ent, dv, lk, sd, er, ed);
            if (rc == 10 && num_tests < MAX_TESTS) begin
                t_name[num_tests]     = nm;
                t_zero_at[num_tests]  = zat;
                t_ndw[num_tests]      = ndw;
                t_wen[num_tests]      = wen;
                t_entry[num_tests]    = ent;
                t_dest[num_tests]     = dv;
                t_lock[num_tests]     = lk;
                t_seed[num_tests]     = sd;
                t_err[num_tests]      = er;
                t_exp_dest[num_tests] = ed;
                num_tests++;
            end else begin
                $display("trace line could not be used: %s", line);
                fail_count++;
            end
        end
        $fclose(fd);
    endtask

    task automatic check_reset();
        cur_name    = "reset_state";
        test_errors = 0;
        if (kv_ready !== 1'b1) begin
            note_mismatch("kv_ready", 32'h1, 32'(kv_ready));
        end
        if (dest_done !== 1'b0) begin
            note_mismatch("dest_done", 32'h0, 32'(dest_done));
        end
        if (error_code !== kv_defines_pkg::KV_SUCCESS) begin
            note_mismatch("error_code", 32'h0, 32'(error_code));
        end
        finish_test();
    endtask

    task automatic run_test(input int t);
        int          k;
        int          i;
        int          j;
        int          n;
        logic        exp_rdy;
        logic        exp_dn;
        logic [31:0] exp_word;
        n           = t_ndw[t];
        cur_name    = t_name[t];
        test_errors = 0;
        // one client result, dword i is seed + i
        num_dwords     = (OFF_W+1)'(n);
        write_en       = t_wen[t][0];
        write_entry    = ENTRY_W'(t_entry[t]);
        write_dest_vld = t_dest[t][DEST_W-1:0];
        lock           = t_lock[t][NUM_ENTRIES-1:0];
        for (i = 0; i < NUM_DW; i++) begin
            dest_data[i*32 +: 32] = t_seed[t] + 32'(i);
        end
        dest_data_avail = 1'b1;

        // cycle k is the state after the k-th edge from start
        for (k = 1; k <= n + 3; k++) begin
            @(negedge clk);
            if (!write_en) begin
                exp_rdy = 1'b1;
            end else if (t_zero_at[t] > 0) begin
                exp_rdy = (k > t_zero_at[t]);
            end else begin
                exp_rdy = (k > n);
            end
            // done one cycle after the last beat, never after zeroize
            exp_dn = write_en && (t_zero_at[t] == 0) && (k == n + 1);
            if (kv_ready !== exp_rdy) begin
                note_mismatch($sformatf("kv_ready cycle %0d", k), 32'(exp_rdy), 32'(kv_ready));
            end
            if (dest_done !== exp_dn) begin
                note_mismatch($sformatf("dest_done cycle %0d", k), 32'(exp_dn), 32'(dest_done));
            end
            if (k == 1 && dest_keyvault !== write_en) begin
                note_mismatch("dest_keyvault", 32'(write_en), 32'(dest_keyvault));
            end
            // start is a level, drop it once sampled
            dest_data_avail = 1'b0;
            zeroize         = (k == t_zero_at[t]);
        end

        if (t_zero_at[t] > 0) begin
            // whole vault wiped
            for (j = 0; j < NUM_ENTRIES; j++) begin
                model_dest[j] = '0;
                for (i = 0; i < NUM_DW; i++) begin
                    model_mem[j][i] = '0;
                end
            end
        end else if (write_en && !lock[write_entry]) begin
            // beat k carries the dword from the top end down
            for (i = 0; i < n; i++) begin
                model_mem[t_entry[t]][i] = t_seed[t] + 32'(NUM_DW - 1 - i);
            end
            model_dest[t_entry[t]] = write_dest_vld;
        end

        if (error_code !== t_err[t][7:0]) begin
            note_mismatch("error_code", t_err[t], 32'(error_code));
        end

        // every offset of the written entry
        for (i = 0; i < NUM_DW; i++) begin
            rd_entry  = write_entry;
            rd_offset = OFF_W'(i);
            @(negedge clk);
            exp_word = model_mem[t_entry[t]][i];
            if (rd_data !== exp_word) begin
                note_mismatch($sformatf("entry %0d offset %0d", t_entry[t], i), exp_word, rd_data);
            end
        end
        if (rd_dest_valid !== t_exp_dest[t][DEST_W-1:0]) begin
            note_mismatch("dest field", t_exp_dest[t], 32'(rd_dest_valid));
        end

        // first dword and dest field of each entry
        for (j = 0; j < NUM_ENTRIES; j++) begin
            rd_entry  = ENTRY_W'(j);
            rd_offset = '0;
            @(negedge clk);
            if (rd_data !== model_mem[j][0]) begin
                note_mismatch($sformatf("entry %0d offset 0", j), model_mem[j][0], rd_data);
            end
            if (rd_dest_valid !== model_dest[j]) begin
                note_mismatch($sformatf("entry %0d dest", j), 32'(model_dest[j]),
                              32'(rd_dest_valid));
            end
        end
        finish_test();
    endtask

    initial begin
        clk             = 1'b0;
        rst_b           = 1'b0;
        zeroize         = 1'b0;
        num_dwords      = '0;
        write_en        = 1'b0;
        write_entry     = '0;
        write_dest_vld  = '0;
        dest_data_avail = 1'b0;
        dest_data       = '0;
        lock            = '0;
        rd_entry        = '0;
        rd_offset       = '0;
        pass_count      = 0;
        fail_count      = 0;
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            model_dest[e] = '0;
            for (int d = 0; d < NUM_DW; d++) begin
                model_mem[e][d] = '0;
            end
        end
        load_trace();
        if (num_tests == 0) begin
            $display("no usable tests in the trace file");
            $display("Testbench failed");
            $finish;
        end else begin
            cycle_limit = num_tests * (NUM_DW + 40);
            repeat (16) @(negedge clk);
            rst_b = 1'b1;
            @(negedge clk);
            check_reset();
            for (int t = 0; t < num_tests; t++) begin
                run_test(t);
            end
            $display("tests %0d, passed %0d, failed %0d",
                     pass_count + fail_count, pass_count, fail_count);
            if (fail_count == 0) begin
                $display("Testbench passed");
            end else begin
                $display("Testbench failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: kv_vault.f
hw/kv_defines_pkg.sv
hw/kv_fsm.sv
hw/kv_offset_counter.sv
hw/kv_write_client.sv
hw/kv_store.sv
hw/kv_vault_top.sv
verification/kv_vault_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the key vault testbench with Verilator and run it
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module kv_vault_tb \
    -f kv_vault.f \
    -o kv_vault_sim

./obj_dir/kv_vault_sim | tee "$LOG"

if grep -q "Testbench failed" "$LOG"; then
    echo "simulation reported a failure, see $LOG"
    exit 1
fi
echo "simulation finished without a reported failure"

// File: verification/kv_vault_trace.txt
# name zero_at num_dwords write_en entry dest_vld(h) lock(h) seed(h) exp_err(h) exp_dest(h)
# zero_at is the transfer cycle that raises zeroize, 0 for none
full_e0      0 16 1 0 2a 00 10000000 00 2a
partial_e0   0  4 1 0 15 00 20000000 00 15
full_e1      0 16 1 1 3f 00 a0000000 00 3f
locked_e1    0 16 1 1 01 02 b0000000 01 3f
unlocked_e2  0  8 1 2 07 02 c0000000 00 07
disabled_e2  0 16 0 2 11 00 d0000000 00 07
partial_e5   0  3 1 5 2c 00 33330000 00 2c
zeroize_e3   5 16 1 3 0f 00 e0000000 00 00
refill_e3    0  2 1 3 20 00 f0000000 00 20
locked_e4    0  3 1 4 18 10 44440000 01 00
single_e7    0  1 1 7 3c 00 12345678 00 3c
